//--- project.f
common/csrDefsPkg.sv
common/irqTypesPkg.sv
interrupts/interruptRegs.sv
interrupts/interruptSelect.sv
logic/trapControlRegs.sv
logic/csrReadMux.sv
logic/interruptCsrTop.sv
bench/interruptCsrTb.sv

//--- run.sh
#!/bin/sh
# Build and run the interrupt CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module interruptCsrTb -f project.f --Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

//--- bench/interruptCsrTb.sv
// Self-checking testbench for interruptCsrTop; assumes sstcSupported off and supervisor mode present
`timescale 1ns/10ps
`default_nettype none

module interruptCsrTb
  import csrDefsPkg::*;
  import irqTypesPkg::*;
();

  // Cycle budgets per test and a timeout of four times their sum
  localparam int resetCycles    = 12;
  localparam int maskCycles     = 90;
  localparam int superCycles    = 150;
  localparam int lineCycles     = 20;
  localparam int sweepCycles    = 370;
  localparam int conflictCycles = 30;
  localparam int timeoutCycles  = 4 * (resetCycles + maskCycles + superCycles + lineCycles
                                       + sweepCycles + conflictCycles);

  logic            clk;
  logic            reset;
  csrAccessT       access;
  logic [1:0]      privMode;
  irqLinesT        lines;
  logic [xlen-1:0] readData;
  irqRequestT      request;

  // Shadow copies of the CSR state
  logic [11:0] mipSw;
  logic [11:0] mieSh;
  logic [11:0] midelegSh;
  logic        mieBit;
  logic        sieBit;

  logic [31:0] lfsrState;
  logic [31:0] v;
  logic        checking;
  int          cycleCount;
  int          checkCount;
  int          errorCount;
  int          testCount;
  int          testErrorsStart;

  interruptCsrTop dut_i (
    .clk      (clk),
    .reset    (reset),
    .access   (access),
    .privMode (privMode),
    .lines    (lines),
    .readData (readData),
    .request  (request)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [11:0] mergeMasked(logic [11:0] old, logic [11:0] data,
                                              logic [11:0] mask);
    return (data & mask) | (old & ~mask);
  endfunction

  // Read-only M bits track the lines and SEIP ORs line with software bit
  function automatic logic [11:0] expectPending();
    logic [11:0] p;
    p = '0;
    p[bitMei] = lines.mExt;
    p[bitMti] = lines.mTimer;
    p[bitMsi] = lines.mSw;
    p[bitSei] = lines.sExt | mipSw[bitSei];
    p[bitSti] = sstcSupported ? lines.sTimer : mipSw[bitSti];
    p[bitSsi] = mipSw[bitSsi];
    return p;
  endfunction

  function automatic logic [31:0] expectRead(logic [11:0] adr);
    logic [31:0] r;
    r = '0;
    case (adr)
      csrAdrMip:     r[11:0] = expectPending();
      csrAdrMie:     r[11:0] = mieSh;
      csrAdrSip:     r[11:0] = expectPending() & midelegSh;
      csrAdrSie:     r[11:0] = mieSh & midelegSh;
      csrAdrMideleg: r[11:0] = midelegSh;
      csrAdrMstatus: begin
        r[statusMie] = mieBit;
        r[statusSie] = sieBit;
      end
      csrAdrSstatus: r[statusSie] = sieBit;
      default:       r = '0;
    endcase
    return r;
  endfunction

  // Rank 0 is the highest priority
  function automatic int priorityBit(int rank);
    case (rank)
      0:       return bitMei;
      1:       return bitMsi;
      2:       return bitMti;
      3:       return bitSei;
      4:       return bitSsi;
      default: return bitSti;
    endcase
  endfunction

  function automatic irqRequestT expectRequest();
    irqRequestT  r;
    logic [11:0] cand;
    int          b;
    logic        taken;
    r = '0;
    cand = expectPending() & mieSh;
    for (int k = 0; k < 6; k++) begin
      b = priorityBit(k);
      // Delegated sources never reach M mode
      if (midelegSh[b]) begin
        taken = (privMode == privU) || ((privMode == privS) && sieBit);
      end else begin
        taken = (privMode != privM) || mieBit;
      end
      if (!r.valid && cand[b] && taken) begin
        r.valid   = 1'b1;
        r.cause   = 4'(b);
        r.targetS = midelegSh[b];
      end
    end
    return r;
  endfunction

  // Shadow registers take the access seen at the same edge as the DUT
  always @(posedge clk) begin
    if (reset) begin
      mipSw     = '0;
      mieSh     = '0;
      midelegSh = '0;
      mieBit    = 1'b0;
      sieBit    = 1'b0;
    end else if (access.mWrite) begin
      case (access.adr)
        csrAdrMip:     mipSw = access.wdata[11:0] & mipWriteMask;
        csrAdrMie:     mieSh = access.wdata[11:0] & mieWriteMask;
        csrAdrMideleg: midelegSh = access.wdata[11:0] & midelegWriteMask;
        csrAdrMstatus: begin
          mieBit = access.wdata[statusMie];
          sieBit = sSupported & access.wdata[statusSie];
        end
        default: ;
      endcase
    end else if (access.sWrite) begin
      case (access.adr)
        csrAdrSip: mipSw = mergeMasked(mipSw, access.wdata[11:0],
                                       mipWriteMask & sFieldMask & midelegSh);
        csrAdrSie: mieSh = mergeMasked(mieSh, access.wdata[11:0],
                                       mieWriteMask & sFieldMask & midelegSh);
        csrAdrSstatus: sieBit = sSupported & access.wdata[statusSie];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic compareValue(string what, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (checking) begin
      compareValue($sformatf("readData at adr %h", access.adr), readData,
                   expectRead(access.adr));
      compareValue("request", {26'd0, request}, {26'd0, expectRequest()});
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] nextLfsr(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomBits(input int count, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < count; k++) begin
      lfsrState = nextLfsr(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic drive(input logic m, input logic s, input logic [11:0] adr,
                       input logic [31:0] data);
    @(posedge clk);
    access <= {m, s, adr, data};
  endtask

  function automatic logic [11:0] csrAt(int i);
    case (i)
      0:       return csrAdrMip;
      1:       return csrAdrMie;
      2:       return csrAdrSip;
      3:       return csrAdrSie;
      4:       return csrAdrMstatus;
      5:       return csrAdrSstatus;
      default: return csrAdrMideleg;
    endcase
  endfunction

  task automatic finishTest(string name);
    testCount++;
    $display("Test %s done with %0d errors", name, errorCount - testErrorsStart);
    testErrorsStart = errorCount;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    access = '0;
    privMode = privM;
    lines = '0;
    lfsrState = 32'h926d;
    checking = 1'b0;
    cycleCount = 0;
    checkCount = 0;
    errorCount = 0;
    testCount = 0;
    testErrorsStart = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    checking <= 1'b1;

    // Everything reads zero with no request
    for (int i = 0; i < 7; i++) begin
      drive(1'b0, 1'b0, csrAt(i), 32'd0);
      @(negedge clk);
      compareValue("readData after reset", readData, 32'd0);
      compareValue("request.valid after reset", {31'd0, request.valid}, 32'd0);
    end
    finishTest("reset");

    // Random writes then readback with lines idle so M pending bits stay low
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 4; j++) begin
        randomBits(32, v);
        drive(1'b1, 1'b0, (j == 3) ? csrAdrMideleg : ((j == 2) ? csrAdrMstatus : csrAt(j)), v);
        drive(1'b0, 1'b0, (j == 3) ? csrAdrMideleg : ((j == 2) ? csrAdrMstatus : csrAt(j)), 0);
      end
      drive(1'b0, 1'b0, csrAdrMip, 32'd0);
      @(negedge clk);
      compareValue("read-only mip bits", readData & {20'd0, mFieldMask}, 32'd0);
    end
    finishTest("write masks");

    // Supervisor views under random delegation
    for (int i = 0; i < 12; i++) begin
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMideleg, v);
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMie, v);
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMip, v);
      randomBits(12, v);
      drive(1'b0, 1'b1, csrAdrSip, v);
      randomBits(12, v);
      drive(1'b0, 1'b1, csrAdrSie, v);
      for (int j = 0; j < 4; j++) begin
        drive(1'b0, 1'b0, csrAt(j), 32'd0);
      end
      randomBits(4, v);
      drive(1'b0, 1'b1, csrAdrSstatus, v);
      drive(1'b0, 1'b0, csrAdrMstatus, 32'd0);
      drive(1'b0, 1'b0, csrAdrSstatus, 32'd0);
    end
    finishTest("supervisor views");

    // One line at a time and then SEIP as line OR software bit
    for (int i = 0; i < 5; i++) begin
      drive(1'b0, 1'b0, csrAdrMip, 32'd0);
      lines <= 5'b00001 << i;
    end
    drive(1'b1, 1'b0, csrAdrMideleg, 32'h200);
    lines <= '0;
    drive(1'b1, 1'b0, csrAdrMip, 32'h200);
    drive(1'b0, 1'b0, csrAdrSip, 32'd0);
    lines <= 5'b01000;
    drive(1'b0, 1'b0, csrAdrMip, 32'd0);
    lines <= '0;
    drive(1'b1, 1'b0, csrAdrMip, 32'd0);
    drive(1'b0, 1'b0, csrAdrMip, 32'd0);
    lines <= 5'b01000;
    drive(1'b0, 1'b0, csrAdrSip, 32'd0);
    lines <= '0;
    finishTest("external lines");

    // Random state sweep where every fourth pass forces M mode
    for (int i = 0; i < 60; i++) begin
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMie, v);
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMideleg, v);
      randomBits(4, v);
      drive(1'b1, 1'b0, csrAdrMstatus, v);
      randomBits(12, v);
      drive(1'b1, 1'b0, csrAdrMip, v);
      randomBits(7, v);
      drive(1'b0, 1'b0, csrAdrMip, 32'd0);
      lines <= v[4:0];
      privMode <= (i % 4 == 0) ? privM : v[6:5];
      drive(1'b0, 1'b0, csrAdrSip, 32'd0);
    end
    lines <= '0;
    privMode <= privM;
    finishTest("priority and gating");

    // Both strobes high
    drive(1'b1, 1'b0, csrAdrMideleg, 32'h222);
    for (int i = 0; i < 12; i++) begin
      randomBits(12, v);
      drive(1'b1, 1'b1, csrAt(i % 6), v);
      drive(1'b0, 1'b0, csrAt(i % 6), 32'd0);
    end
    finishTest("write conflict");

    checking <= 1'b0;
    @(posedge clk);
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/interruptCsrTop.sv
// Privilege checks on accesses belong to the core; one access and one request level per cycle
`timescale 1ns/10ps
`default_nettype none

module interruptCsrTop
  import csrDefsPkg::*;
  import irqTypesPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  csrAccessT       access,
  input  logic [1:0]      privMode,
  input  irqLinesT        lines,
  output logic [xlen-1:0] readData,
  output irqRequestT      request
);

  logic [11:0] mideleg;
  globalEnT    globalEn;
  irqWordU     pending;
  irqWordU     enabled;

  // Delegation and mstatus enables
  trapControlRegs trapControlRegs_i (
    .clk      (clk),
    .reset    (reset),
    .access   (access),
    .mideleg  (mideleg),
    .globalEn (globalEn)
  );

  // mip and mie
  interruptRegs interruptRegs_i (
    .clk     (clk),
    .reset   (reset),
    .access  (access),
    .lines   (lines),
    .mideleg (mideleg),
    .pending (pending),
    .enabled (enabled)
  );

  interruptSelect interruptSelect_i (
    .pending  (pending),
    .enabled  (enabled),
    .mideleg  (mideleg),
    .globalEn (globalEn),
    .privMode (privMode),
    .request  (request)
  );

  csrReadMux csrReadMux_i (
    .access   (access),
    .pending  (pending),
    .enabled  (enabled),
    .mideleg  (mideleg),
    .globalEn (globalEn),
    .readData (readData)
  );

endmodule

`default_nettype wire

//--- logic/csrReadMux.sv
// Read data is combinational from the address; unimplemented addresses read zero
`timescale 1ns/10ps
`default_nettype none

module csrReadMux
  import csrDefsPkg::*;
  import irqTypesPkg::*;
(
  input  csrAccessT       access,
  input  irqWordU         pending,
  input  irqWordU         enabled,
  input  logic [11:0]     mideleg,
  input  globalEnT        globalEn,
  output logic [xlen-1:0] readData
);

  always_comb begin
    readData = '0;
    case (access.adr)
      csrAdrMip:     readData[11:0] = pending.raw;
      csrAdrMie:     readData[11:0] = enabled.raw;
      // Supervisor views show delegated fields only
      csrAdrSip:     readData[11:0] = pending.raw & mideleg;
      csrAdrSie:     readData[11:0] = enabled.raw & mideleg;
      csrAdrMideleg: readData[11:0] = mideleg;
      csrAdrMstatus: begin
        readData[statusMie] = globalEn.mie;
        readData[statusSie] = globalEn.sie;
      end
      // MIE hidden from S mode
      csrAdrSstatus: readData[statusSie] = globalEn.sie;
      default:       readData = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/trapControlRegs.sv
// Holds only MIE and SIE of mstatus; other status fields and medeleg live elsewhere in the core
`timescale 1ns/10ps
`default_nettype none

module trapControlRegs
  import csrDefsPkg::*;
  import irqTypesPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csrAccessT   access,
  output logic [11:0] mideleg,
  output globalEnT    globalEn
);

  logic writeMideleg;
  logic writeMstatus;
  logic writeSstatus;
  logic newSie;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  assign writeMideleg = access.mWrite & (access.adr == csrAdrMideleg);
  assign writeMstatus = access.mWrite & (access.adr == csrAdrMstatus);
  // Supervisor strobe ignored while machine strobe is high
  assign writeSstatus = access.sWrite & ~access.mWrite & (access.adr == csrAdrSstatus);

  // SIE stuck low without S mode
  assign newSie = sSupported & access.wdata[statusSie];

  //////////////////////////////
  // Registers
  //////////////////////////////

  // Delegation mask, S-level bits only
  always_ff @(posedge clk) begin
    if (reset) begin
      mideleg <= '0;
    end else if (writeMideleg) begin
      mideleg <= access.wdata[11:0] & midelegWriteMask;
    end
  end

  // Global enables
  always_ff @(posedge clk) begin
    if (reset) begin
      globalEn <= '0;
    end else if (writeMstatus) begin
      globalEn.mie <= access.wdata[statusMie];
      globalEn.sie <= newSie;
    end else if (writeSstatus) begin
      // sstatus reaches SIE only
      globalEn.sie <= newSie;
    end
  end

endmodule

`default_nettype wire

//--- interrupts/interruptSelect.sv
// Fixed priority MEI, MSI, MTI, SEI, SSI, STI regardless of delegation; privilege 2 takes only M-level
`timescale 1ns/10ps
`default_nettype none

module interruptSelect
  import csrDefsPkg::*;
  import irqTypesPkg::*;
(
  input  irqWordU     pending,
  input  irqWordU     enabled,
  input  logic [11:0] mideleg,
  input  globalEnT    globalEn,
  input  logic [1:0]  privMode,
  output irqRequestT  request
);

  logic [11:0] candidates;
  logic        mAllowed;
  logic        sAllowed;
  logic [11:0] mTaken;
  logic [11:0] sTaken;
  irqWordU     takeable;

  //////////////////////////////
  // Gating
  //////////////////////////////

  // Pending and enabled
  assign candidates = pending.raw & enabled.raw;

  // M-level interrupts always preempt lower privilege
  assign mAllowed = (privMode != privM) | globalEn.mie;

  // Delegated ones never interrupt M mode
  assign sAllowed = (privMode == privU) | ((privMode == privS) & globalEn.sie);

  assign mTaken = candidates & ~mideleg & {12{mAllowed}};
  assign sTaken = candidates & mideleg & {12{sAllowed}};

  assign takeable.raw = mTaken | sTaken;

  //////////////////////////////
  // Priority pick
  //////////////////////////////

  always_comb begin
    request = '0;
    if (takeable.fields.mei) begin
      request.valid   = 1'b1;
      request.cause   = causeMei;
      request.targetS = mideleg[bitMei];
    end else if (takeable.fields.msi) begin
      request.valid   = 1'b1;
      request.cause   = causeMsi;
      request.targetS = mideleg[bitMsi];
    end else if (takeable.fields.mti) begin
      request.valid   = 1'b1;
      request.cause   = causeMti;
      request.targetS = mideleg[bitMti];
    end else if (takeable.fields.sei) begin
      // S-level sources may land in either mode
      request.valid   = 1'b1;
      request.cause   = causeSei;
      request.targetS = mideleg[bitSei];
    end else if (takeable.fields.ssi) begin
      request.valid   = 1'b1;
      request.cause   = causeSsi;
      request.targetS = mideleg[bitSsi];
    end else if (takeable.fields.sti) begin
      request.valid   = 1'b1;
      request.cause   = causeSti;
      request.targetS = mideleg[bitSti];
    end
  end

endmodule

`default_nettype wire

//--- interrupts/interruptRegs.sv
// Lines must be synchronous to clk; MEIP, MTIP and MSIP are read-only and track their lines
`timescale 1ns/10ps
`default_nettype none

module interruptRegs
  import csrDefsPkg::*;
  import irqTypesPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csrAccessT   access,
  input  irqLinesT    lines,
  input  logic [11:0] mideleg,
  output irqWordU     pending,
  output irqWordU     enabled
);

  logic        writeMip;
  logic        writeMie;
  logic        writeSip;
  logic        writeSie;
  logic        sStrobe;
  logic [11:0] sipWriteMask;
  logic [11:0] sieWriteMask;
  logic [11:0] mipWritable;
  logic [11:0] mieReg;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  // Machine strobe overrides a simultaneous supervisor strobe
  assign sStrobe  = access.sWrite & ~access.mWrite;
  assign writeMip = access.mWrite & (access.adr == csrAdrMip);
  assign writeMie = access.mWrite & (access.adr == csrAdrMie);
  assign writeSip = sStrobe & (access.adr == csrAdrSip);
  assign writeSie = sStrobe & (access.adr == csrAdrSie);

  // Supervisor view reaches only delegated S fields
  assign sipWriteMask = mipWriteMask & sFieldMask & mideleg;
  assign sieWriteMask = mieWriteMask & sFieldMask & mideleg;

  //////////////////////////////
  // Registers
  //////////////////////////////

  // Software-writable part of mip
  always_ff @(posedge clk) begin
    if (reset) begin
      mipWritable <= '0;
    end else if (writeMip) begin
      mipWritable <= access.wdata[11:0] & mipWriteMask;
    end else if (writeSip) begin
      // Keep fields outside the S view
      mipWritable <= (access.wdata[11:0] & sipWriteMask) | (mipWritable & ~sipWriteMask);
    end
  end

  // mie holds M and S enables
  always_ff @(posedge clk) begin
    if (reset) begin
      mieReg <= '0;
    end else if (writeMie) begin
      mieReg <= access.wdata[11:0] & mieWriteMask;
    end else if (writeSie) begin
      mieReg <= (access.wdata[11:0] & sieWriteMask) | (mieReg & ~sieWriteMask);
    end
  end

  //////////////////////////////
  // Pending merge
  //////////////////////////////

  always_comb begin
    pending.raw = '0;
    pending.fields.mei = lines.mExt;
    pending.fields.mti = lines.mTimer;
    pending.fields.msi = lines.mSw;
    // SEIP is the line or the software copy
    pending.fields.sei = sSupported & (lines.sExt | mipWritable[bitSei]);
    // STIP follows the line only with timer compare
    pending.fields.sti = sstcSupported ? (sSupported & lines.sTimer) : mipWritable[bitSti];
    pending.fields.ssi = mipWritable[bitSsi];
  end

  assign enabled.raw = mieReg;

endmodule

`default_nettype wire

//--- common/irqTypesPkg.sv
// Bundled access, line and request types; the access data width follows xlen from csrDefsPkg
`default_nettype none

package irqTypesPkg;

  import csrDefsPkg::*;

  //////////////////////////////
  // Bus-side bundles
  //////////////////////////////

  // One CSR access per cycle, the address also picks read data
  typedef struct packed {
    logic             mWrite;
    logic             sWrite;
    logic [11:0]      adr;
    logic [xlen-1:0]  wdata;
  } csrAccessT;

  // External interrupt sources, level sensitive
  typedef struct packed {
    logic mExt;
    logic sExt;
    logic mTimer;
    logic sTimer;
    logic mSw;
  } irqLinesT;

  // mip/mie layout, MSB first
  typedef struct packed {
    logic mei;
    logic res10;
    logic sei;
    logic res8;
    logic mti;
    logic res6;
    logic sti;
    logic res4;
    logic msi;
    logic res2;
    logic ssi;
    logic res0;
  } irqFieldsT;

  // Masked as a raw word, decoded by field in the selector
  typedef union packed {
    logic [11:0] raw;
    irqFieldsT   fields;
  } irqWordU;

  // mstatus global enables
  typedef struct packed {
    logic mie;
    logic sie;
  } globalEnT;

  // Interrupt request toward the trap logic
  typedef struct packed {
    logic       valid;
    logic [3:0] cause;
    logic       targetS;
  } irqRequestT;

endpackage

`default_nettype wire

//--- common/csrDefsPkg.sv
// CSR constants for a 32-bit hart with M and S modes and no user interrupts, shared by all blocks
`default_nettype none

package csrDefsPkg;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  // CSR data width
  localparam int xlen = 32;

  // Supervisor mode present
  localparam bit sSupported = 1'b1;
  // Timer-compare extension off, so STIP stays writable in mip
  localparam bit sstcSupported = 1'b0;

  //////////////////////////////
  // CSR addresses
  //////////////////////////////

  localparam logic [11:0] csrAdrMstatus = 12'h300;
  localparam logic [11:0] csrAdrMideleg = 12'h303;
  localparam logic [11:0] csrAdrMie     = 12'h304;
  localparam logic [11:0] csrAdrMip     = 12'h344;
  localparam logic [11:0] csrAdrSstatus = 12'h100;
  localparam logic [11:0] csrAdrSie     = 12'h104;
  localparam logic [11:0] csrAdrSip     = 12'h144;

  // Interrupt field positions in mip and mie
  localparam int bitSsi = 1;
  localparam int bitMsi = 3;
  localparam int bitSti = 5;
  localparam int bitMti = 7;
  localparam int bitSei = 9;
  localparam int bitMei = 11;

  // Write masks follow the configuration above
  localparam logic [11:0] mipWriteMask =
    !sSupported ? 12'h000 : (sstcSupported ? 12'h202 : 12'h222);
  localparam logic [11:0] mieWriteMask = sSupported ? 12'hAAA : 12'h888;
  localparam logic [11:0] sFieldMask = 12'h222;
  localparam logic [11:0] mFieldMask = 12'h888;
  // Only S-level interrupts can be handed down
  localparam logic [11:0] midelegWriteMask = sSupported ? 12'h222 : 12'h000;

  // Global enable bits in mstatus and sstatus
  localparam int statusSie = 1;
  localparam int statusMie = 3;

  // Privilege levels
  localparam logic [1:0] privU = 2'd0;
  localparam logic [1:0] privS = 2'd1;
  localparam logic [1:0] privM = 2'd3;

  // Interrupt cause codes match the field positions
  localparam logic [3:0] causeSsi = 4'(bitSsi);
  localparam logic [3:0] causeMsi = 4'(bitMsi);
  localparam logic [3:0] causeSti = 4'(bitSti);
  localparam logic [3:0] causeMti = 4'(bitMti);
  localparam logic [3:0] causeSei = 4'(bitSei);
  localparam logic [3:0] causeMei = 4'(bitMei);

endpackage

`default_nettype wire
